//--- common/mem_pkg.sv
package mem_pkg;

    localparam int WORD_W     = 32;
    localparam int LANES      = 4;
    localparam int BANK_ID_W  = 2;
    localparam int ROW_W      = 12;
    localparam int WORD_IDX_W = 14;

    // Byte address fields
    localparam int WORD_LSB   = 2;
    localparam int THREAD_LSB = 16;

    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [LANES*WORD_W-1:0] line_t;
    typedef logic [31:0]             mem_addr_t;
    typedef logic [WORD_IDX_W-1:0]   word_idx_t;
    typedef logic [ROW_W-1:0]        bank_addr_t;
    typedef logic [BANK_ID_W-1:0]    bank_id_t;

    // One port's request as issued by a ray-tracing core
    typedef struct packed {
        logic      we;
        logic      re;
        logic      full;
        mem_addr_t addr;
        line_t     wdata;
    } mem_req_t;

    // Request after lane to bank routing, indexed by bank
    typedef struct packed {
        logic                   we;
        logic                   rd;
        logic                   full;
        bank_addr_t [LANES-1:0] row;
        word_t [LANES-1:0]      wdata;
        bank_id_t               lane0_bank;
    } bank_req_t;

endpackage

//--- design/single_port_ram.sv
`timescale 1ns/10ps

module single_port_ram
    import mem_pkg::*;
#(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 32
) (
    input  logic       clk,
    input  logic       we,
    input  word_t      data,
    input  bank_addr_t addr,
    output word_t      q
);

    logic [DATA_WIDTH-1:0] mem [0:2**ADDR_WIDTH-1];

    // Memory starts cleared
    initial begin
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            mem[i] = '0;
        end
    end

    // Read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

//--- mem_main/mem_req_decode.sv
`timescale 1ns/10ps

module mem_req_decode
    import mem_pkg::*;
#(
    parameter int NUM_THREAD = 8,
    localparam int TW = (NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1
) (
    input  logic           clk,
    input  logic           rst_n,
    input  mem_req_t       req,
    output bank_req_t      dreq,
    output logic [TW-1:0]  thread
);

    word_idx_t word;
    bank_req_t dreq_nxt;

    assign word = req.addr[WORD_LSB +: WORD_IDX_W];

    // Lane k lands in bank (word + k) mod 4, index wraps at 14 bits
    always_comb begin
        word_idx_t idx;

        dreq_nxt            = '0;
        dreq_nxt.we         = req.we;
        dreq_nxt.rd         = req.re;
        dreq_nxt.full       = req.full;
        dreq_nxt.lane0_bank = word[BANK_ID_W-1:0];
        for (int k = 0; k < LANES; k++) begin
            idx = word + word_idx_t'(k);
            dreq_nxt.row[idx[BANK_ID_W-1:0]]   = idx[WORD_IDX_W-1:BANK_ID_W];
            dreq_nxt.wdata[idx[BANK_ID_W-1:0]] = req.wdata[k*WORD_W +: WORD_W];
        end
    end

    // Stage 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dreq   <= '0;
            thread <= '0;
        end else begin
            dreq   <= dreq_nxt;
            thread <= req.addr[THREAD_LSB +: TW];
        end
    end

endmodule

//--- mem_main/mem_bank_select.sv
`timescale 1ns/10ps

module mem_bank_select
    import mem_pkg::*;
#(
    parameter int NUM_PORT   = 4,
    parameter int NUM_THREAD = 8,
    localparam int TW = (NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  bank_req_t [NUM_PORT-1:0]              dreq,
    input  logic [NUM_PORT-1:0][TW-1:0]           thread,
    output logic [NUM_THREAD-1:0][LANES-1:0]      bank_we,
    output bank_addr_t [NUM_THREAD-1:0][LANES-1:0] bank_row,
    output word_t [NUM_THREAD-1:0][LANES-1:0]     bank_wdata
);

    logic [NUM_THREAD-1:0][LANES-1:0]       we_nxt;
    bank_addr_t [NUM_THREAD-1:0][LANES-1:0] row_nxt;
    word_t [NUM_THREAD-1:0][LANES-1:0]      wdata_nxt;

    // Walk ports from the top so the lowest matching port is the last to assign
    always_comb begin
        logic hit;
        logic bank_wr;

        we_nxt    = '0;
        row_nxt   = '0;
        wdata_nxt = '0;
        for (int t = 0; t < NUM_THREAD; t++) begin
            for (int b = 0; b < LANES; b++) begin
                for (int p = NUM_PORT - 1; p >= 0; p--) begin
                    hit     = (thread[p] == TW'(t));
                    bank_wr = dreq[p].we &&
                              (dreq[p].full || dreq[p].lane0_bank == bank_id_t'(b));
                    if (hit && (dreq[p].rd || dreq[p].we)) begin
                        row_nxt[t][b] = dreq[p].row[b];
                    end
                    if (hit && dreq[p].we) begin
                        wdata_nxt[t][b] = dreq[p].wdata[b];
                    end
                    // Enables merge across every port
                    we_nxt[t][b] = we_nxt[t][b] | (hit & bank_wr);
                end
            end
        end
    end

    // Stage 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_we    <= '0;
            bank_row   <= '0;
            bank_wdata <= '0;
        end else begin
            bank_we    <= we_nxt;
            bank_row   <= row_nxt;
            bank_wdata <= wdata_nxt;
        end
    end

endmodule

//--- mem_main/mem_read_return.sv
`timescale 1ns/10ps

module mem_read_return
    import mem_pkg::*;
#(
    parameter int NUM_PORT   = 4,
    parameter int NUM_THREAD = 8,
    localparam int TW = (NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [NUM_PORT-1:0]         re,
    input  logic [NUM_PORT-1:0][TW-1:0] thread,
    input  bank_id_t [NUM_PORT-1:0]     lane0_bank,
    input  line_t [NUM_THREAD-1:0]      q,
    output line_t [NUM_PORT-1:0]        rdata,
    output logic [NUM_PORT-1:0]         rd_rdy
);

    // re is taken raw, so five taps line up with the stage 4 register
    logic [4:0][NUM_PORT-1:0]           re_dly;
    logic [1:0][NUM_PORT-1:0][TW-1:0]   thread_dly;
    bank_id_t [3:0][NUM_PORT-1:0]       lane0_dly;
    line_t [NUM_PORT-1:0]               line_sel;
    line_t [NUM_PORT-1:0]               line_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            re_dly     <= '0;
            thread_dly <= '0;
            lane0_dly  <= '0;
            line_sel   <= '0;
            line_q     <= '0;
        end else begin
            re_dly     <= {re_dly[3:0], re};
            thread_dly <= {thread_dly[0], thread};
            lane0_dly  <= {lane0_dly[2:0], lane0_bank};
            // Stage 3 thread pick, stage 4 hold
            for (int p = 0; p < NUM_PORT; p++) begin
                line_sel[p] <= q[thread_dly[1][p]];
            end
            line_q <= line_sel;
        end
    end

    assign rd_rdy = re_dly[4];

    // Banks back to address order
    always_comb begin
        bank_id_t src;

        for (int p = 0; p < NUM_PORT; p++) begin
            for (int k = 0; k < LANES; k++) begin
                src = lane0_dly[3][p] + bank_id_t'(k);
                rdata[p][k*WORD_W +: WORD_W] = line_q[p][src*WORD_W +: WORD_W];
            end
        end
    end

endmodule

//--- design/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top
    import mem_pkg::*;
#(
    parameter int NUM_PORT   = 4,
    parameter int NUM_THREAD = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_req_t [NUM_PORT-1:0] req,
    output line_t [NUM_PORT-1:0]    rdata,
    output logic [NUM_PORT-1:0]     rd_rdy
);

    localparam int TW = (NUM_THREAD > 1) ? $clog2(NUM_THREAD) : 1;

    wire bank_req_t [NUM_PORT-1:0]             dreq;
    wire logic [NUM_PORT-1:0][TW-1:0]          thread;
    wire logic [NUM_PORT-1:0]                  re;
    wire bank_id_t [NUM_PORT-1:0]              lane0_bank;
    wire logic [NUM_THREAD-1:0][LANES-1:0]     bank_we;
    wire bank_addr_t [NUM_THREAD-1:0][LANES-1:0] bank_row;
    wire word_t [NUM_THREAD-1:0][LANES-1:0]    bank_wdata;
    wire line_t [NUM_THREAD-1:0]               q_line;

    for (genvar p = 0; p < NUM_PORT; p++) begin : g_port
        mem_req_decode #(
            .NUM_THREAD (NUM_THREAD)
        ) u_decode (
            .clk    (clk),
            .rst_n  (rst_n),
            .req    (req[p]),
            .dreq   (dreq[p]),
            .thread (thread[p])
        );

        assign re[p]         = req[p].re;
        assign lane0_bank[p] = dreq[p].lane0_bank;
    end

    mem_bank_select #(
        .NUM_PORT   (NUM_PORT),
        .NUM_THREAD (NUM_THREAD)
    ) u_bank_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .dreq       (dreq),
        .thread     (thread),
        .bank_we    (bank_we),
        .bank_row   (bank_row),
        .bank_wdata (bank_wdata)
    );

    // Four word-interleaved banks per thread region
    for (genvar t = 0; t < NUM_THREAD; t++) begin : g_thread
        for (genvar b = 0; b < LANES; b++) begin : g_bank
            single_port_ram #(
                .ADDR_WIDTH (ROW_W),
                .DATA_WIDTH (WORD_W)
            ) u_ram (
                .clk  (clk),
                .we   (bank_we[t][b]),
                .data (bank_wdata[t][b]),
                .addr (bank_row[t][b]),
                .q    (q_line[t][b*WORD_W +: WORD_W])
            );
        end
    end

    mem_read_return #(
        .NUM_PORT   (NUM_PORT),
        .NUM_THREAD (NUM_THREAD)
    ) u_read_return (
        .clk        (clk),
        .rst_n      (rst_n),
        .re         (re),
        .thread     (thread),
        .lane0_bank (lane0_bank),
        .q          (q_line),
        .rdata      (rdata),
        .rd_rdy     (rd_rdy)
    );

endmodule

//--- verif/mem_tb_clk.sv
`timescale 1ns/10ps

module mem_tb_clk #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release lines up with the stimulus offset
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

//--- verif/mem_tb.sv
`timescale 1ns/10ps

module mem_tb
    import mem_pkg::*;
();

    localparam int NUM_PORT   = 4;
    localparam int NUM_THREAD = 8;
    localparam int CLK_PERIOD = 20;
    localparam int DRAIN_MAX  = 20;
    localparam int N_LINE     = 6;
    localparam int N_WORD     = 4;
    // Worst case of each test in cycles, drains included
    localparam int TEST_CYCLES = 12 + N_LINE * (4 + DRAIN_MAX) + N_WORD * (3 + DRAIN_MAX)
                               + (2 + DRAIN_MAX) + (16 + DRAIN_MAX) + (2 + DRAIN_MAX);
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

    logic                    clk;
    logic                    rst_n;
    mem_req_t [NUM_PORT-1:0] req;
    line_t [NUM_PORT-1:0]    rdata;
    logic [NUM_PORT-1:0]     rd_rdy;

    word_t       model [int];
    line_t       exp_line [NUM_PORT][$];
    int          exp_cyc [NUM_PORT][$];
    int          rdy_count [NUM_PORT];
    logic [31:0] rng = 32'h4fbc;
    int          cyc = 0;
    int          tests = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errs = 0;
    string       test_name = "init";

    mem_tb_clk #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (2)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsys_top #(
        .NUM_PORT   (NUM_PORT),
        .NUM_THREAD (NUM_THREAD)
    ) uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .rdata  (rdata),
        .rd_rdy (rd_rdy)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic line_t rand_line();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    function automatic int word_key(input int thr, input word_idx_t idx);
        return thr * (2 ** WORD_IDX_W) + int'(idx);
    endfunction

    // Words never written read as zero
    function automatic word_t model_word(input int thr, input word_idx_t idx);
        int key;
        key = word_key(thr, idx);
        if (model.exists(key)) begin
            return model[key];
        end
        return '0;
    endfunction

    function automatic line_t model_line(input int thr, input word_idx_t idx);
        line_t l;
        for (int k = 0; k < LANES; k++) begin
            l[k*WORD_W +: WORD_W] = model_word(thr, idx + word_idx_t'(k));
        end
        return l;
    endfunction

    task automatic model_write(input int thr, input word_idx_t idx, input logic full,
                               input line_t data);
        for (int k = 0; k < (full ? LANES : 1); k++) begin
            model[word_key(thr, idx + word_idx_t'(k))] = data[k*WORD_W +: WORD_W];
        end
    endtask

    function automatic mem_addr_t addr_of(input int thr, input word_idx_t idx);
        return (mem_addr_t'(thr) << THREAD_LSB) | (mem_addr_t'(idx) << WORD_LSB);
    endfunction

    task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errs++;
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic advance();
        tick();
        req = '0;
    endtask

    task automatic drive_write(input int p, input int thr, input word_idx_t idx,
                               input logic full, input line_t data);
        req[p].we    = 1'b1;
        req[p].full  = full;
        req[p].addr  = addr_of(thr, idx);
        req[p].wdata = data;
    endtask

    task automatic drive_read(input int p, input int thr, input word_idx_t idx);
        req[p].re   = 1'b1;
        req[p].addr = addr_of(thr, idx);
        exp_line[p].push_back(model_line(thr, idx));
        exp_cyc[p].push_back(cyc);
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORT; p++) begin
            n += exp_line[p].size();
        end
        return n;
    endfunction

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending() != 0 && n < DRAIN_MAX) begin
            tick();
            n++;
        end
        if (pending() != 0) begin
            errors++;
            test_errs++;
            $display("%s: read data did not come back within %0d cycles", test_name, DRAIN_MAX);
            for (int p = 0; p < NUM_PORT; p++) begin
                exp_line[p].delete();
                exp_cyc[p].delete();
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
        tests++;
        for (int p = 0; p < NUM_PORT; p++) begin
            rdy_count[p] = 0;
        end
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("%s: done, no errors", test_name);
        end else begin
            $display("%s: done, %0d errors", test_name, test_errs);
        end
    endtask

    task automatic test_reset();
        start_test("reset");
        repeat (10) begin
            tick();
            check("rd_rdy", '0, 128'(rd_rdy));
        end
        end_test();
    endtask

    task automatic test_full_line();
        int        thr;
        int        p;
        word_idx_t idx;
        line_t     data;
        start_test("full_line");
        for (int i = 0; i < N_LINE; i++) begin
            p    = i % NUM_PORT;
            thr  = int'(next_rand() % NUM_THREAD);
            // First pass sits at the top of the index so lines wrap
            idx  = (i == 0) ? word_idx_t'(14'h3ffe) : word_idx_t'(next_rand());
            data = rand_line();
            drive_write(p, thr, idx, 1'b1, data);
            model_write(thr, idx, 1'b1, data);
            advance();
            for (int j = 0; j < 3; j++) begin
                drive_read(p, thr, idx + word_idx_t'((j == 2) ? 3 : j));
                advance();
            end
            wait_drain();
        end
        end_test();
    endtask

    task automatic test_single_word();
        int        thr;
        int        p;
        word_idx_t idx;
        line_t     data;
        start_test("single_word");
        for (int i = 0; i < N_WORD; i++) begin
            p    = (i + 1) % NUM_PORT;
            thr  = int'(next_rand() % NUM_THREAD);
            idx  = word_idx_t'(next_rand());
            data = rand_line();
            drive_write(p, thr, idx, 1'b1, data);
            model_write(thr, idx, 1'b1, data);
            advance();
            // Upper lanes carry junk that must not land
            data = rand_line();
            drive_write(p, thr, idx, 1'b0, data);
            model_write(thr, idx, 1'b0, data);
            advance();
            drive_read(p, thr, idx);
            advance();
            wait_drain();
        end
        end_test();
    endtask

    task automatic test_parallel();
        int        base;
        int        thr [NUM_PORT];
        word_idx_t idx [NUM_PORT];
        line_t     data;
        start_test("parallel_ports");
        base = int'(next_rand() % NUM_THREAD);
        for (int p = 0; p < NUM_PORT; p++) begin
            thr[p] = (base + p) % NUM_THREAD;
            idx[p] = word_idx_t'(next_rand());
            data   = rand_line();
            drive_write(p, thr[p], idx[p], 1'b1, data);
            model_write(thr[p], idx[p], 1'b1, data);
        end
        advance();
        for (int p = 0; p < NUM_PORT; p++) begin
            drive_read(p, thr[p], idx[p]);
        end
        advance();
        wait_drain();
        for (int p = 0; p < NUM_PORT; p++) begin
            check($sformatf("port %0d rd_rdy pulses", p), 128'(1), 128'(rdy_count[p]));
        end
        end_test();
    endtask

    task automatic test_back_to_back();
        int        thr;
        word_idx_t idx [8];
        line_t     data;
        start_test("back_to_back");
        thr = int'(next_rand() % NUM_THREAD);
        for (int i = 0; i < 8; i++) begin
            idx[i] = word_idx_t'(next_rand());
            data   = rand_line();
            drive_write(0, thr, idx[i], 1'b1, data);
            model_write(thr, idx[i], 1'b1, data);
            advance();
        end
        for (int i = 0; i < 8; i++) begin
            drive_read(3, thr, idx[i]);
            advance();
        end
        wait_drain();
        check("port 3 rd_rdy pulses", 128'(8), 128'(rdy_count[3]));
        end_test();
    endtask

    task automatic test_collision();
        int        thr;
        word_idx_t idx;
        line_t     data_a;
        line_t     data_b;
        start_test("collision");
        thr    = int'(next_rand() % NUM_THREAD);
        idx    = word_idx_t'(next_rand());
        data_a = rand_line();
        data_b = rand_line();
        drive_write(1, thr, idx, 1'b1, data_a);
        drive_write(2, thr, idx, 1'b1, data_b);
        // Port 1 outranks port 2, so its line goes in last
        model_write(thr, idx, 1'b1, data_b);
        model_write(thr, idx, 1'b1, data_a);
        advance();
        drive_read(0, thr, idx);
        drive_read(3, thr, idx);
        advance();
        wait_drain();
        end_test();
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Read return checker, pops the oldest read per port
    always @(posedge clk) begin
        #1;
        for (int p = 0; p < NUM_PORT; p++) begin
            if (rd_rdy[p] === 1'b1) begin
                rdy_count[p]++;
                if (exp_line[p].size() == 0) begin
                    errors++;
                    test_errs++;
                    $display("%s: port %0d raised rd_rdy with no read outstanding",
                             test_name, p);
                end else begin
                    check($sformatf("port %0d latency", p), 128'(5),
                          128'(cyc - exp_cyc[p][0]));
                    check($sformatf("port %0d rdata", p), exp_line[p][0], rdata[p]);
                    void'(exp_line[p].pop_front());
                    void'(exp_cyc[p].pop_front());
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        req = '0;
        wait (rst_n === 1'b1);
        tick();
        test_reset();
        test_full_line();
        test_single_word();
        test_parallel();
        test_back_to_back();
        test_collision();
        $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
common/mem_pkg.sv
design/single_port_ram.sv
mem_main/mem_req_decode.sv
mem_main/mem_bank_select.sv
mem_main/mem_read_return.sv
design/mem_subsys_top.sv
verif/mem_tb_clk.sv
verif/mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mem_tb -f filelist.f -o mem_tb_sim \
    && ./obj_dir/mem_tb_sim | tee /dev/stderr | grep -qF "Result: PASSED" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
